// File: common/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Address and instruction word width
`define FETCH_XLEN 32

// First fetch address out of reset
`define FETCH_RESET_PC 32'h0000_1000

// Instruction buffer entries
// Must stay a power of two so the pointers wrap by themselves
`define FETCH_IBUFF_DEPTH 4

// Target buffer entries
// Indexed by PC bits 5:2 with the upper PC bits as tag
`define FETCH_BTB_ENTRIES 16

`endif

// File: common/fetch_pkg.sv
package fetch_pkg;

    // Bus master states
    typedef enum logic [1:0] {
        IDLE,   // No read on the bus
        BUSY,   // Read pending, data is wanted
        DRAIN   // Read pending, data is dropped after a flush
    } fetch_state_t;

    // Where the next fetch PC comes from
    // Listed from lowest to highest priority
    typedef enum logic [1:0] {
        SEQ,    // PC plus 4 or hold
        PRED,   // Target buffer prediction
        BR,     // Branch unit redirect
        ROB     // Reorder buffer redirect
    } redirect_src_t;

endpackage

// File: btb/btb_predictor.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module btb_predictor (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`FETCH_XLEN-1:0] lookup_pc,        // Current fetch address
    output logic                   pred_taken,
    output logic [`FETCH_XLEN-1:0] pred_target,
    input  logic                   update_btb,       // One-cycle strobe from branch unit
    input  logic [`FETCH_XLEN-1:0] resolved_pc,
    input  logic [`FETCH_XLEN-1:0] resolved_target,
    input  logic                   resolved_taken
);

    localparam int IDX_W = $clog2(`FETCH_BTB_ENTRIES);
    localparam int TAG_W = `FETCH_XLEN - IDX_W - 2;  // Word aligned, bits 1:0 dropped

    // Entry storage
    logic [`FETCH_BTB_ENTRIES-1:0] valid;
    logic [TAG_W-1:0]              tag_mem [`FETCH_BTB_ENTRIES];
    logic [`FETCH_XLEN-1:0]        tgt_mem [`FETCH_BTB_ENTRIES];
    logic [1:0]                    ctr_mem [`FETCH_BTB_ENTRIES];  // 2-bit saturating

    // Lookup side
    logic [IDX_W-1:0] lk_idx;
    logic [TAG_W-1:0] lk_tag;
    logic             lk_hit;

    // Update side
    logic [IDX_W-1:0] up_idx;
    logic [TAG_W-1:0] up_tag;
    logic             up_hit;
    logic             alloc;
    logic             train;

    assign lk_idx = lookup_pc[IDX_W+1:2];
    assign lk_tag = lookup_pc[`FETCH_XLEN-1:IDX_W+2];
    assign lk_hit = valid[lk_idx] && (tag_mem[lk_idx] == lk_tag);

    // Weakly or strongly taken predicts taken
    assign pred_taken  = lk_hit && ctr_mem[lk_idx][1];
    assign pred_target = tgt_mem[lk_idx];

    assign up_idx = resolved_pc[IDX_W+1:2];
    assign up_tag = resolved_pc[`FETCH_XLEN-1:IDX_W+2];
    assign up_hit = valid[up_idx] && (tag_mem[up_idx] == up_tag);

    // Only a taken branch earns a new entry
    assign alloc = update_btb && resolved_taken && !up_hit;
    assign train = update_btb && up_hit;               // Existing entry, move counter

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (alloc) begin
            valid[up_idx] <= 1'b1;  // Replaces whatever sat there
        end
    end

    // Tag, target and counter arrays
    always_ff @(posedge clk) begin
        if (alloc) begin
            tag_mem[up_idx] <= up_tag;
            tgt_mem[up_idx] <= resolved_target;
            ctr_mem[up_idx] <= 2'd2;                   // Start weakly taken
        end else if (train) begin
            if (resolved_taken) begin
                tgt_mem[up_idx] <= resolved_target;    // Indirect targets may move
                if (ctr_mem[up_idx] != 2'd3) begin
                    ctr_mem[up_idx] <= ctr_mem[up_idx] + 2'd1;
                end
            end else if (ctr_mem[up_idx] != 2'd0) begin
                ctr_mem[up_idx] <= ctr_mem[up_idx] - 2'd1;  // Saturate at 0
            end
        end
    end

endmodule

// File: rtl/fetch_pc_gen.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module fetch_pc_gen (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     rob_redirect,   // Highest priority
    input  logic [`FETCH_XLEN-1:0]   rob_target,
    input  logic                     br_redirect,
    input  logic [`FETCH_XLEN-1:0]   br_target,
    input  logic                     fetch_done,     // Ack accepted this cycle
    input  logic                     pred_taken,
    input  logic [`FETCH_XLEN-1:0]   pred_target,
    output logic [`FETCH_XLEN-1:0]   fetch_pc,
    output logic                     flush,
    output fetch_pkg::redirect_src_t next_src
);

    import fetch_pkg::*;

    logic [`FETCH_XLEN-1:0] pc_seq;
    logic [`FETCH_XLEN-1:0] pc_next;

    assign pc_seq = fetch_pc + `FETCH_XLEN'(4);

    // Fixed priority ROB, BR, PRED, SEQ
    always_comb begin
        if (rob_redirect) begin
            next_src = ROB;
        end else if (br_redirect) begin
            next_src = BR;
        end else if (fetch_done && pred_taken) begin
            next_src = PRED;                 // Predictor looked up this same PC
        end else begin
            next_src = SEQ;
        end
    end

    always_comb begin
        case (next_src)
            ROB:     pc_next = rob_target;
            BR:      pc_next = br_target;
            PRED:    pc_next = pred_target;
            default: pc_next = fetch_done ? pc_seq : fetch_pc;  // Hold while read pending
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_pc <= `FETCH_RESET_PC;
        end else begin
            fetch_pc <= pc_next;
        end
    end

    // Any redirect throws away work in flight
    assign flush = (next_src == ROB) || (next_src == BR);

endmodule

// File: rtl/fetch_bus_master.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module fetch_bus_master (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`FETCH_XLEN-1:0] fetch_pc,
    input  logic                   flush,       // Redirect this cycle
    input  logic                   ibuff_full,
    output logic                   wb_cyc,
    output logic                   wb_stb,
    output logic [`FETCH_XLEN-1:0] wb_adr,
    output logic                   wb_we,
    input  logic [`FETCH_XLEN-1:0] wb_dat_i,
    input  logic                   wb_ack,
    output logic                   fetch_done,  // Push strobe for the buffer
    output logic [`FETCH_XLEN-1:0] fetch_word
);

    import fetch_pkg::*;

    fetch_state_t state;
    fetch_state_t state_nxt;
    logic         start;

    // Room check only here, the pending read owns the spare slot
    assign start = (state == IDLE) && !ibuff_full && !flush;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_nxt = BUSY;
                end
            end
            BUSY: begin
                if (wb_ack) begin
                    state_nxt = IDLE;   // Done, or dropped if flush hits the ack cycle
                end else if (flush) begin
                    state_nxt = DRAIN;  // Cannot abort a classic cycle
                end
            end
            DRAIN: begin
                if (wb_ack) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Address held for the whole cycle
    always_ff @(posedge clk) begin
        if (start) begin
            wb_adr <= fetch_pc;
        end
    end

    assign wb_cyc = (state != IDLE);   // Drops the cycle after ack
    assign wb_stb = wb_cyc;
    assign wb_we  = 1'b0;              // Fetch never writes

    // Data is sampled in the ack cycle itself
    assign fetch_done = (state == BUSY) && wb_ack && !flush;
    assign fetch_word = wb_dat_i;

endmodule

// File: rtl/ibuff.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module ibuff (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush,
    input  logic                   push,
    input  logic [`FETCH_XLEN-1:0] push_word,
    input  logic [`FETCH_XLEN-1:0] push_pc,
    output logic                   full,
    output logic                   inst_valid,
    output logic [`FETCH_XLEN-1:0] inst,
    output logic [`FETCH_XLEN-1:0] inst_pc,
    input  logic                   inst_ready
);

    localparam int PTR_W = $clog2(`FETCH_IBUFF_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [`FETCH_XLEN-1:0] word_mem [`FETCH_IBUFF_DEPTH];
    logic [`FETCH_XLEN-1:0] pc_mem   [`FETCH_IBUFF_DEPTH];
    logic [PTR_W-1:0]       rd_ptr;
    logic [PTR_W-1:0]       wr_ptr;
    logic [CNT_W-1:0]       count;
    logic                   pop;

    assign pop = inst_valid && inst_ready;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin      // Flush wins over push
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // Both or neither
            endcase
        end
    end

    // Payload storage
    always_ff @(posedge clk) begin
        if (push && !flush) begin
            word_mem[wr_ptr] <= push_word;
            pc_mem[wr_ptr]   <= push_pc;
        end
    end

    // One slot short of depth for the read still on the bus
    assign full = (count >= CNT_W'(`FETCH_IBUFF_DEPTH - 1));

    assign inst_valid = (count != '0);
    assign inst       = word_mem[rd_ptr];
    assign inst_pc    = pc_mem[rd_ptr];

endmodule

// File: rtl/fetch_top.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module fetch_top (
    input  logic                   clk,
    input  logic                   rst_n,
    output logic                   wb_cyc,          // Wishbone classic master
    output logic                   wb_stb,
    output logic [`FETCH_XLEN-1:0] wb_adr,
    output logic                   wb_we,
    input  logic [`FETCH_XLEN-1:0] wb_dat_i,
    input  logic                   wb_ack,
    input  logic                   rob_redirect,
    input  logic [`FETCH_XLEN-1:0] rob_target,
    input  logic                   br_redirect,
    input  logic [`FETCH_XLEN-1:0] br_target,
    input  logic                   update_btb,
    input  logic [`FETCH_XLEN-1:0] resolved_pc,
    input  logic [`FETCH_XLEN-1:0] resolved_target,
    input  logic                   resolved_taken,
    output logic                   inst_valid,      // To decode
    output logic [`FETCH_XLEN-1:0] inst,
    output logic [`FETCH_XLEN-1:0] inst_pc,
    input  logic                   inst_ready
);

    import fetch_pkg::*;

    logic [`FETCH_XLEN-1:0] fetch_pc;
    logic [`FETCH_XLEN-1:0] fetch_word;
    logic [`FETCH_XLEN-1:0] pred_target;
    logic                   pred_taken;
    logic                   fetch_done;
    logic                   flush;
    logic                   ibuff_full;
    redirect_src_t          next_src;       // Probed by the testbench

    btb_predictor u_btb (
        .clk             (clk),
        .rst_n           (rst_n),
        .lookup_pc       (fetch_pc),
        .pred_taken      (pred_taken),
        .pred_target     (pred_target),
        .update_btb      (update_btb),
        .resolved_pc     (resolved_pc),
        .resolved_target (resolved_target),
        .resolved_taken  (resolved_taken)
    );

    fetch_pc_gen u_pc_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .rob_redirect (rob_redirect),
        .rob_target   (rob_target),
        .br_redirect  (br_redirect),
        .br_target    (br_target),
        .fetch_done   (fetch_done),
        .pred_taken   (pred_taken),
        .pred_target  (pred_target),
        .fetch_pc     (fetch_pc),
        .flush        (flush),
        .next_src     (next_src)
    );

    fetch_bus_master u_bus (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_pc   (fetch_pc),
        .flush      (flush),
        .ibuff_full (ibuff_full),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_adr     (wb_adr),
        .wb_we      (wb_we),
        .wb_dat_i   (wb_dat_i),
        .wb_ack     (wb_ack),
        .fetch_done (fetch_done),
        .fetch_word (fetch_word)
    );

    // PC still equals the fetched address in the ack cycle
    ibuff u_ibuff (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .push       (fetch_done),
        .push_word  (fetch_word),
        .push_pc    (fetch_pc),
        .full       (ibuff_full),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .inst_ready (inst_ready)
    );

endmodule

// File: bench/fetch_checker.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module fetch_checker (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    wb_cyc,
    input logic                    wb_stb,
    input logic [`FETCH_XLEN-1:0]  wb_adr,
    input logic                    wb_ack,
    input logic                    ibuff_full,
    input fetch_pkg::fetch_state_t state
);

    import fetch_pkg::*;

    int fail_count = 0;  // Failed assertion count

    // Bus released in the cycle after ack
    a_cyc_drop: assert property (@(posedge clk) disable iff (!rst_n)
        wb_cyc && wb_ack |=> !wb_cyc)
        else begin
            $error("wb_cyc still high in the cycle after ack");
            fail_count++;
        end

    a_adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && !wb_ack |=> $stable(wb_adr))
        else begin
            $error("wb_adr changed during a pending read");
            fail_count++;
        end

    // Classic cycle only ends on ack
    a_cyc_held: assert property (@(posedge clk) disable iff (!rst_n)
        wb_cyc && !wb_ack |=> wb_cyc)
        else begin
            $error("wb_cyc dropped before ack");
            fail_count++;
        end

    // No new read while the buffer is full
    a_no_start_full: assert property (@(posedge clk) disable iff (!rst_n)
        (state == IDLE) && ibuff_full |=> !wb_cyc)
        else begin
            $error("read started while the instruction buffer was full");
            fail_count++;
        end

endmodule

// File: bench/fetch_tb.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module fetch_tb;

    import fetch_pkg::*;

    localparam logic [31:0] WORD_KEY = 32'h5a5a_0000;  // Memory returns address XOR this
    localparam logic [31:0] BR_PC    = 32'h0000_2040;
    localparam logic [31:0] BR_TGT   = 32'h0000_3000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic [31:0] wb_adr;
    logic        wb_we;
    logic [31:0] wb_dat_i;
    logic        wb_ack;
    logic        rob_redirect;
    logic [31:0] rob_target;
    logic        br_redirect;
    logic [31:0] br_target;
    logic        update_btb;
    logic [31:0] resolved_pc;
    logic [31:0] resolved_target;
    logic        resolved_taken;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] inst_pc;
    logic        inst_ready;

    integer      seed = 32'h07b73c37;
    int          err_count;
    int          stall_count;  // Timeouts and other plain failures
    int          ready_pct;    // Decode acceptance rate in percent
    string       test_name;
    logic        mem_busy;
    int          mem_wait;
    logic        delivered;
    logic [31:0] got_pc;

    // Reference model of the target buffer and the expected stream
    logic [31:0]                   exp_pc;
    logic [`FETCH_BTB_ENTRIES-1:0] m_valid;
    logic [25:0]                   m_tag [`FETCH_BTB_ENTRIES];
    logic [31:0]                   m_tgt [`FETCH_BTB_ENTRIES];
    logic [1:0]                    m_ctr [`FETCH_BTB_ENTRIES];

    fetch_top uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .wb_cyc          (wb_cyc),
        .wb_stb          (wb_stb),
        .wb_adr          (wb_adr),
        .wb_we           (wb_we),
        .wb_dat_i        (wb_dat_i),
        .wb_ack          (wb_ack),
        .rob_redirect    (rob_redirect),
        .rob_target      (rob_target),
        .br_redirect     (br_redirect),
        .br_target       (br_target),
        .update_btb      (update_btb),
        .resolved_pc     (resolved_pc),
        .resolved_target (resolved_target),
        .resolved_taken  (resolved_taken),
        .inst_valid      (inst_valid),
        .inst            (inst),
        .inst_pc         (inst_pc),
        .inst_ready      (inst_ready)
    );

    bind fetch_bus_master fetch_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_adr     (wb_adr),
        .wb_ack     (wb_ack),
        .ibuff_full (ibuff_full),
        .state      (state)
    );

    always #2 clk = ~clk;  // 4 ns period

    function automatic int urand(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Word aligned address in a small window where entries alias and hit
    function automatic logic [31:0] near_addr();
        return 32'h0000_1000 + 32'd4 * 32'(urand(64));
    endfunction

    function automatic logic [31:0] model_next(input logic [31:0] pc);
        logic [3:0] idx;
        idx = pc[5:2];
        if (m_valid[idx] && (m_tag[idx] == pc[31:6]) && m_ctr[idx][1]) begin
            return m_tgt[idx];  // Predicted taken
        end
        return pc + 32'd4;
    endfunction

    task automatic model_update(input logic [31:0] pc, input logic [31:0] tgt,
                                input logic taken);
        logic [3:0] idx;
        logic       hit;
        idx = pc[5:2];
        hit = m_valid[idx] && (m_tag[idx] == pc[31:6]);
        if (!hit) begin
            if (taken) begin  // Allocate weakly taken
                m_valid[idx] = 1'b1;
                m_tag[idx]   = pc[31:6];
                m_tgt[idx]   = tgt;
                m_ctr[idx]   = 2'd2;
            end
        end else if (taken) begin
            m_tgt[idx] = tgt;
            if (m_ctr[idx] != 2'd3) m_ctr[idx] = m_ctr[idx] + 2'd1;
        end else if (m_ctr[idx] != 2'd0) begin
            m_ctr[idx] = m_ctr[idx] - 2'd1;
        end
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error %s expected %h actual %h", name, expected, actual);
            err_count++;
        end
    endtask

    // Drive phase 1 ns after the edge with the memory responder
    task automatic drive_cycle();
        @(posedge clk);
        #1;
        rob_redirect = 1'b0;
        br_redirect  = 1'b0;
        update_btb   = 1'b0;
        inst_ready   = (urand(100) < ready_pct);
        wb_ack       = 1'b0;
        if (wb_cyc && wb_stb && !mem_busy) begin  // New read on the bus
            mem_busy = 1'b1;
            mem_wait = urand(4);                  // 0 to 3 extra cycles
        end
        if (mem_busy) begin
            if (mem_wait == 0) begin
                wb_ack   = 1'b1;
                wb_dat_i = wb_adr ^ WORD_KEY;
                mem_busy = 1'b0;
            end else begin
                mem_wait--;
            end
        end
    endtask

    // Sample phase at the falling edge where inputs have settled
    task automatic sample_cycle();
        @(negedge clk);
        delivered = 1'b0;
        // Classic read cycle with stb alongside cyc and never a write
        compare(test_name, 32'(wb_cyc), 32'(wb_stb));
        compare(test_name, 32'd0, 32'(wb_we));
        if (inst_valid && inst_ready) begin
            compare(test_name, exp_pc, inst_pc);
            compare(test_name, exp_pc ^ WORD_KEY, inst);
            got_pc    = inst_pc;
            delivered = 1'b1;
            exp_pc    = model_next(exp_pc);
        end
        if (rob_redirect || br_redirect) begin
            compare(test_name, 32'(rob_redirect ? ROB : BR), 32'(uut.next_src));
            if (update_btb) model_update(resolved_pc, resolved_target, resolved_taken);
            exp_pc = rob_redirect ? rob_target : br_target;  // ROB first
        end
    endtask

    task automatic clock_cycle();
        drive_cycle();
        sample_cycle();
    endtask

    task automatic wait_delivery(output logic [31:0] pc);
        int n;
        n = 0;
        do begin
            clock_cycle();
            n++;
        end while (!delivered && n < 200);
        pc = got_pc;
        if (!delivered) begin
            $display("Timeout: no instruction delivered within 200 cycles in %s", test_name);
            stall_count++;
        end
    endtask

    task automatic expect_pc(input logic [31:0] pc);
        logic [31:0] seen;
        wait_delivery(seen);
        if (delivered) compare(test_name, pc, seen);
    endtask

    // Directed redirect with decode stalled in that cycle
    task automatic redirect_now(input logic rob, input logic upd);
        drive_cycle();
        inst_ready   = 1'b0;
        br_redirect  = 1'b1;
        rob_redirect = rob;
        update_btb   = upd;
        sample_cycle();
    endtask

    initial begin
        int          i;
        int          n_random;
        int          chk_fails;
        logic [31:0] seen;
        rst_n = 1'b0;
        wb_dat_i = '0;
        wb_ack = 1'b0;
        rob_redirect = 1'b0;
        rob_target = '0;
        br_redirect = 1'b0;
        br_target = '0;
        update_btb = 1'b0;
        resolved_pc = '0;
        resolved_target = '0;
        resolved_taken = 1'b0;
        inst_ready = 1'b0;
        mem_busy = 1'b0;
        mem_wait = 0;
        err_count = 0;
        stall_count = 0;
        n_random = 0;
        delivered = 1'b0;
        got_pc = '0;
        ready_pct = 100;
        m_valid = '0;
        exp_pc = `FETCH_RESET_PC;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_name = "reset_stream";
        for (i = 0; i < 20; i++) expect_pc(`FETCH_RESET_PC + 32'd4 * 32'(i));

        test_name = "backpressure";
        ready_pct = 30;
        for (i = 0; i < 30; i++) wait_delivery(seen);  // Model checks each one

        test_name = "br_redirect";
        ready_pct = 0;
        repeat (12) clock_cycle();  // Buffer fills with stale words
        ready_pct = 100;
        br_target = 32'h0000_4000;
        redirect_now(1'b0, 1'b0);
        expect_pc(32'h0000_4000);
        test_name  = "rob_over_br";
        rob_target = 32'h0000_5000;
        br_target  = 32'h0000_6000;
        redirect_now(1'b1, 1'b0);
        expect_pc(32'h0000_5000);

        test_name       = "taken_update";
        resolved_pc     = BR_PC;
        resolved_target = BR_TGT;
        resolved_taken  = 1'b1;
        br_target       = BR_PC - 32'd8;
        redirect_now(1'b0, 1'b1);
        expect_pc(BR_PC - 32'd8);
        expect_pc(BR_PC - 32'd4);
        expect_pc(BR_PC);
        expect_pc(BR_TGT);

        // Counter 2 to 1 and then 1 to 0
        test_name      = "not_taken_update";
        resolved_taken = 1'b0;
        br_target      = BR_PC;
        repeat (2) begin
            redirect_now(1'b0, 1'b1);
            expect_pc(BR_PC);
            expect_pc(BR_PC + 32'd4);
        end

        test_name = "random_mix";
        for (i = 0; i < 2000; i++) begin
            if (i % 100 == 0) ready_pct = 20 + urand(80);
            drive_cycle();
            if (urand(100) < 4) begin
                rob_redirect    = (urand(2) == 1);
                br_redirect     = (urand(2) == 1) || !rob_redirect;
                rob_target      = near_addr();
                br_target       = near_addr();
                update_btb      = (urand(2) == 1);  // Only with a redirect
                resolved_pc     = near_addr();
                resolved_target = near_addr();
                resolved_taken  = (urand(4) != 0);
            end
            sample_cycle();
            if (delivered) n_random++;
        end
        if (n_random == 0) begin
            $display("No instruction was delivered during the random mix");
            stall_count++;
        end

        chk_fails = uut.u_bus.u_checker.fail_count;
        $display("Mismatches %0d, timeouts %0d, assertion failures %0d",
                 err_count, stall_count, chk_fails);
        if (err_count == 0 && stall_count == 0 && chk_fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+common
common/fetch_pkg.sv
btb/btb_predictor.sv
rtl/fetch_pc_gen.sv
rtl/fetch_bus_master.sv
rtl/ibuff.sv
rtl/fetch_top.sv
bench/fetch_checker.sv
bench/fetch_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the fetch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module fetch_tb -o fetch_sim

out=$(./obj_dir/fetch_sim +verilator+error+limit+1000)
echo "$out"

# Pass only if the testbench printed its pass line
echo "$out" | grep -qx 'Everything OK'
